/* hdl/kmeans_ctrl_pkg.sv */
// k-means controller package
// phase encoding, register file map, shared widths and the
// packed control bundles that leave the controller
package kmeans_ctrl_pkg;

	localparam int PT_ADDR_W  = 9;  // point address in RAM
	localparam int REG_ID_W   = 4;  // register file register number
	localparam int MAX_CENT   = 8;  // centroid slots in the register map
	localparam int CENT_IDX_W = $clog2(MAX_CENT);

	// controller phase
	typedef enum logic [3:0] {
		PH_IDLE,
		PH_LOAD_RD,      // present centroid register to the core
		PH_LOAD_WR,      // classification block latches it
		PH_POINT_FIRST,  // first point address of a scan
		PH_FILL,
		PH_CLASSIFY,
		PH_DRAIN1,
		PH_DRAIN2,
		PH_MEAN,         // divider kicks off
		PH_CHECK,        // centroid walk, wait for convergence result
		PH_WRITEBACK,
		PH_IRQ
	} kmeans_phase_e;

	// register file map
	typedef enum logic [REG_ID_W-1:0] {
		REG_STATUS,
		REG_GO,
		REG_CENT_1,
		REG_CENT_2,
		REG_CENT_3,
		REG_CENT_4,
		REG_CENT_5,
		REG_CENT_6,
		REG_CENT_7,
		REG_CENT_8,
		REG_RAM_ADDR,
		REG_RAM_DATA,
		REG_FIRST_ADDR,
		REG_LAST_ADDR
	} reg_id_e;

	// RAM port, all strobes active low
	typedef struct packed {
		logic [PT_ADDR_W-1:0] addr;
		logic                 cs_n;
		logic                 oe_n;
		logic                 we_n;
	} ram_ctrl_t;

	// classification block controls
	typedef struct packed {
		logic in_reg_en;        // point input register
		logic accum_en;         // per-centroid accumulators
		logic pipe3_rst_n;      // third pipe stage clear
		logic first_iteration;  // centroids come from the register file
	} classify_ctrl_t;

	// mean divider and convergence check controls
	typedef struct packed {
		logic divider_en;
		logic conv_reg_en;
		logic conv_rst_n;
	} converge_ctrl_t;

	// centroid counter width, at least one bit
	function automatic int cent_cnt_w(input int n_cent);
		return (n_cent > 1) ? $clog2(n_cent) : 1;
	endfunction

	// register holding centroid k
	function automatic reg_id_e cent_reg(input logic [CENT_IDX_W-1:0] k);
		return reg_id_e'(REG_ID_W'(REG_CENT_1) + REG_ID_W'(k));
	endfunction

endpackage

/* hdl/kmeans_phase_fsm.sv */
// k-means phase FSM
// steps load, scan, drain, mean and check phases per iteration,
// writes back on convergence and owns the interrupt flag
`timescale 1ns/1ps

module kmeans_phase_fsm (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          go,
	input  logic                          last_point,
	input  logic                          cent_last,
	input  logic                          converge_res_available,
	input  logic                          has_converged,
	output kmeans_ctrl_pkg::kmeans_phase_e phase,
	output logic                          irq
);

	kmeans_ctrl_pkg::kmeans_phase_e phase_nxt;
	logic                           go_seen;  // go sampled while idle

	assign go_seen = (phase == kmeans_ctrl_pkg::PH_IDLE) && go;

	always_comb begin
		phase_nxt = phase;  // stay by default
		case (phase)
			kmeans_ctrl_pkg::PH_IDLE: begin
				if (go)
					phase_nxt = kmeans_ctrl_pkg::PH_LOAD_RD;
			end
			kmeans_ctrl_pkg::PH_LOAD_RD:
				phase_nxt = kmeans_ctrl_pkg::PH_LOAD_WR;
			kmeans_ctrl_pkg::PH_LOAD_WR: begin
				// one rd/wr pair per centroid
				if (cent_last)
					phase_nxt = kmeans_ctrl_pkg::PH_POINT_FIRST;
				else
					phase_nxt = kmeans_ctrl_pkg::PH_LOAD_RD;
			end
			kmeans_ctrl_pkg::PH_POINT_FIRST:
				phase_nxt = kmeans_ctrl_pkg::PH_FILL;
			kmeans_ctrl_pkg::PH_FILL:
				phase_nxt = kmeans_ctrl_pkg::PH_CLASSIFY;
			kmeans_ctrl_pkg::PH_CLASSIFY: begin
				if (last_point)  // last address of the window issued
					phase_nxt = kmeans_ctrl_pkg::PH_DRAIN1;
			end
			kmeans_ctrl_pkg::PH_DRAIN1:
				phase_nxt = kmeans_ctrl_pkg::PH_DRAIN2;
			kmeans_ctrl_pkg::PH_DRAIN2:
				phase_nxt = kmeans_ctrl_pkg::PH_MEAN;
			kmeans_ctrl_pkg::PH_MEAN:
				phase_nxt = kmeans_ctrl_pkg::PH_CHECK;
			kmeans_ctrl_pkg::PH_CHECK: begin
				// has_converged only means something with the valid
				if (converge_res_available) begin
					if (has_converged)
						phase_nxt = kmeans_ctrl_pkg::PH_WRITEBACK;
					else
						phase_nxt = kmeans_ctrl_pkg::PH_POINT_FIRST;  // another iteration
				end
			end
			kmeans_ctrl_pkg::PH_WRITEBACK: begin
				if (cent_last)
					phase_nxt = kmeans_ctrl_pkg::PH_IRQ;
			end
			kmeans_ctrl_pkg::PH_IRQ:
				phase_nxt = kmeans_ctrl_pkg::PH_IDLE;
			default:
				phase_nxt = kmeans_ctrl_pkg::PH_IDLE;  // unused codes
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			phase <= kmeans_ctrl_pkg::PH_IDLE;
			irq   <= 1'b0;
		end else begin
			phase <= phase_nxt;
			// set on the way out of PH_IRQ, dropped by the next go
			if (phase == kmeans_ctrl_pkg::PH_IRQ)
				irq <= 1'b1;
			else if (go_seen)
				irq <= 1'b0;
		end
	end

endmodule

/* hdl/point_addr_gen.sv */
// point address generator
// walks first_addr..last_addr once per iteration and opens the
// RAM read window only for the cycles that carry those addresses
`timescale 1ns/1ps

module point_addr_gen (
	input  logic                                    clk,
	input  logic                                    rst_n,
	input  kmeans_ctrl_pkg::kmeans_phase_e          phase,
	input  logic [kmeans_ctrl_pkg::PT_ADDR_W-1:0]   first_addr,
	input  logic [kmeans_ctrl_pkg::PT_ADDR_W-1:0]   last_addr,
	output kmeans_ctrl_pkg::ram_ctrl_t              ram,
	output logic                                    last_point
);

	logic [kmeans_ctrl_pkg::PT_ADDR_W-1:0] offset_q;  // next offset after first_addr
	logic [kmeans_ctrl_pkg::PT_ADDR_W-1:0] cur_addr;
	logic [kmeans_ctrl_pkg::PT_ADDR_W-1:0] addr_q;
	logic                                  issuing;   // scan phases
	logic                                  active;    // address goes out this cycle
	logic                                  scan_done; // last_addr already issued
	logic                                  win_n_q;   // shared cs_n / oe_n

	assign issuing = phase inside {kmeans_ctrl_pkg::PH_POINT_FIRST,
		kmeans_ctrl_pkg::PH_FILL, kmeans_ctrl_pkg::PH_CLASSIFY};
	assign cur_addr = (phase == kmeans_ctrl_pkg::PH_POINT_FIRST) ?
		first_addr : first_addr + offset_q;
	// short windows finish before PH_CLASSIFY, window stays shut after that
	assign active     = issuing & ~scan_done;
	assign last_point = scan_done | (active & (cur_addr == last_addr));

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			offset_q  <= '0;
			scan_done <= 1'b0;
			win_n_q   <= 1'b1;  // RAM deselected
		end else begin
			win_n_q   <= ~active;
			scan_done <= issuing & last_point;  // clears once the scan phases end
			if (phase == kmeans_ctrl_pkg::PH_POINT_FIRST)
				offset_q <= kmeans_ctrl_pkg::PT_ADDR_W'(1);
			else if (issuing)
				offset_q <= offset_q + 1'b1;
		end
	end

	// address register
	always_ff @(posedge clk) begin
		if (active)
			addr_q <= cur_addr;
	end

	assign ram = '{addr: addr_q, cs_n: win_n_q, oe_n: win_n_q, we_n: 1'b1};  // read only

endmodule

/* hdl/centroid_seq.sv */
// centroid sequencer
// loads centroids from the register file, walks the centroid
// enables through each convergence check and writes the result back
`timescale 1ns/1ps

module centroid_seq #(
	parameter int N_CENT = 8
) (
	input  logic                                             clk,
	input  logic                                             rst_n,
	input  kmeans_ctrl_pkg::kmeans_phase_e                   phase,
	output logic [N_CENT-1:0]                                centroid_en,
	output logic [kmeans_ctrl_pkg::cent_cnt_w(N_CENT)-1:0]   cent_cnt,
	output logic                                             cent_last,
	output logic                                             go_signal,
	output logic                                             reg_write,
	output kmeans_ctrl_pkg::reg_id_e                         reg_num
);

	localparam int CNT_W = kmeans_ctrl_pkg::cent_cnt_w(N_CENT);

	logic [CNT_W-1:0]         cnt_nxt;
	logic [N_CENT-1:0]        cnt_onehot;
	kmeans_ctrl_pkg::reg_id_e cnt_reg;    // REG_CENT_1 + cnt
	logic                     walk_done;  // walk finished in this check

	assign cent_last  = (cent_cnt == CNT_W'(N_CENT - 1));
	assign cnt_nxt    = cent_last ? '0 : cent_cnt + 1'b1;  // wrap at N_CENT
	assign cnt_onehot = N_CENT'(1) << cent_cnt;
	assign cnt_reg    = kmeans_ctrl_pkg::cent_reg(kmeans_ctrl_pkg::CENT_IDX_W'(cent_cnt));

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			cent_cnt    <= '0;
			walk_done   <= 1'b0;
			centroid_en <= '0;
			go_signal   <= 1'b0;
			reg_write   <= 1'b0;
			reg_num     <= kmeans_ctrl_pkg::REG_STATUS;
		end else begin
			centroid_en <= '0;  // enables off unless a phase drives them
			reg_write   <= 1'b0;
			case (phase)
				kmeans_ctrl_pkg::PH_IDLE:
					cent_cnt <= '0;
				kmeans_ctrl_pkg::PH_LOAD_RD: begin
					centroid_en <= cnt_onehot;
					reg_num     <= cnt_reg;  // read, reg_write stays low
					go_signal   <= 1'b1;     // core muxes RAM to us
				end
				kmeans_ctrl_pkg::PH_LOAD_WR: begin
					centroid_en <= centroid_en;  // keep while classifier latches
					cent_cnt    <= cnt_nxt;
				end
				kmeans_ctrl_pkg::PH_MEAN: begin
					cent_cnt  <= '0;
					walk_done <= 1'b0;
				end
				kmeans_ctrl_pkg::PH_CHECK: begin
					// one pass 0..N_CENT-1, then zero till the result
					if (!walk_done) begin
						centroid_en <= cnt_onehot;
						cent_cnt    <= cnt_nxt;
						walk_done   <= cent_last;
					end
				end
				kmeans_ctrl_pkg::PH_WRITEBACK: begin
					reg_write <= 1'b1;
					reg_num   <= cnt_reg;
					cent_cnt  <= cnt_nxt;
				end
				kmeans_ctrl_pkg::PH_IRQ:
					go_signal <= 1'b0;
				default: ;  // scan and drain phases
			endcase
		end
	end

endmodule

/* hdl/iteration_ctrl.sv */
// iteration control decode
// turns the phase into registered enables and clears for the
// classification, mean divider and convergence check blocks
`timescale 1ns/1ps

module iteration_ctrl (
	input  logic                           clk,
	input  logic                           rst_n,
	input  kmeans_ctrl_pkg::kmeans_phase_e phase,
	output kmeans_ctrl_pkg::classify_ctrl_t classify,
	output kmeans_ctrl_pkg::converge_ctrl_t converge
);

	kmeans_ctrl_pkg::classify_ctrl_t classify_nxt;
	kmeans_ctrl_pkg::converge_ctrl_t converge_nxt;

	always_comb begin
		// point input register open across the whole scan
		classify_nxt.in_reg_en = phase inside {kmeans_ctrl_pkg::PH_POINT_FIRST,
			kmeans_ctrl_pkg::PH_FILL, kmeans_ctrl_pkg::PH_CLASSIFY};
		// accumulate until the last point leaves the pipe
		classify_nxt.accum_en = phase inside {kmeans_ctrl_pkg::PH_CLASSIFY,
			kmeans_ctrl_pkg::PH_DRAIN1};
		classify_nxt.pipe3_rst_n = (phase != kmeans_ctrl_pkg::PH_POINT_FIRST);

		// register file centroids only before the first scan
		if (phase == kmeans_ctrl_pkg::PH_IDLE)
			classify_nxt.first_iteration = 1'b1;
		else if (phase == kmeans_ctrl_pkg::PH_POINT_FIRST)
			classify_nxt.first_iteration = 1'b0;
		else
			classify_nxt.first_iteration = classify.first_iteration;

		converge_nxt.divider_en = phase inside {kmeans_ctrl_pkg::PH_DRAIN2,
			kmeans_ctrl_pkg::PH_MEAN, kmeans_ctrl_pkg::PH_CHECK};
		// sample divider results from mean until the check resolves
		converge_nxt.conv_reg_en = phase inside {kmeans_ctrl_pkg::PH_MEAN,
			kmeans_ctrl_pkg::PH_CHECK};
		// clear at each new scan and before fresh means, held while idle
		converge_nxt.conv_rst_n = !(phase inside {kmeans_ctrl_pkg::PH_IDLE,
			kmeans_ctrl_pkg::PH_POINT_FIRST, kmeans_ctrl_pkg::PH_DRAIN2});
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			classify <= '{in_reg_en: 1'b0, accum_en: 1'b0, pipe3_rst_n: 1'b0,
				first_iteration: 1'b1};
			converge <= '{divider_en: 1'b0, conv_reg_en: 1'b0, conv_rst_n: 1'b0};
		end else begin
			classify <= classify_nxt;
			converge <= converge_nxt;
		end
	end

endmodule

/* hdl/kmeans_ctrl_top.sv */
// k-means sequencing controller
// phase FSM plus point address, centroid and iteration blocks,
// all outputs registered one clock behind the phase
`timescale 1ns/1ps

module kmeans_ctrl_top #(
	parameter int N_CENT = 8  // 1..MAX_CENT
) (
	input  logic                                           clk,
	input  logic                                           rst_n,
	// core handshake
	input  logic                                           go,
	input  logic [kmeans_ctrl_pkg::PT_ADDR_W-1:0]          first_addr,
	input  logic [kmeans_ctrl_pkg::PT_ADDR_W-1:0]          last_addr,
	output logic                                           irq,
	output logic                                           go_signal,
	output kmeans_ctrl_pkg::reg_id_e                       reg_num,
	output logic                                           reg_write,
	// point RAM
	output kmeans_ctrl_pkg::ram_ctrl_t                     ram,
	// classification block
	output kmeans_ctrl_pkg::classify_ctrl_t                classify,
	output logic [N_CENT-1:0]                              centroid_en,
	output logic [kmeans_ctrl_pkg::cent_cnt_w(N_CENT)-1:0] cent_cnt,
	// divider and convergence check
	output kmeans_ctrl_pkg::converge_ctrl_t                converge,
	input  logic                                           converge_res_available,
	input  logic                                           has_converged
);

	kmeans_ctrl_pkg::kmeans_phase_e phase;
	logic                           last_point;  // scan reached last_addr
	logic                           cent_last;   // centroid counter at N_CENT-1

	kmeans_phase_fsm u_fsm (
		.clk                    (clk),
		.rst_n                  (rst_n),
		.go                     (go),
		.last_point             (last_point),
		.cent_last              (cent_last),
		.converge_res_available (converge_res_available),
		.has_converged          (has_converged),
		.phase                  (phase),
		.irq                    (irq)
	);

	point_addr_gen u_addr (
		.clk        (clk),
		.rst_n      (rst_n),
		.phase      (phase),
		.first_addr (first_addr),
		.last_addr  (last_addr),
		.ram        (ram),
		.last_point (last_point)
	);

	centroid_seq #(.N_CENT(N_CENT)) u_cent (
		.clk         (clk),
		.rst_n       (rst_n),
		.phase       (phase),
		.centroid_en (centroid_en),
		.cent_cnt    (cent_cnt),
		.cent_last   (cent_last),
		.go_signal   (go_signal),
		.reg_write   (reg_write),
		.reg_num     (reg_num)
	);

	iteration_ctrl u_iter (
		.clk      (clk),
		.rst_n    (rst_n),
		.phase    (phase),
		.classify (classify),
		.converge (converge)
	);

endmodule

/* verification/kmeans_ctrl_tb.sv */
// k-means controller testbench
// three back to back runs with LFSR windows and convergence counts,
// checks load, point scan, centroid walks, writeback and interrupt
`timescale 1ns/1ps

module kmeans_ctrl_tb;

	localparam int N_CENT = 8;
	localparam int N_RUNS = 3;

	// one run of the test
	typedef struct packed {
		int first;  // first point address
		int len;    // window length 1..20
		int k;      // result number that reports convergence
	} run_t;

	logic                                           clk;
	logic                                           rst_n;
	logic                                           go;
	logic [kmeans_ctrl_pkg::PT_ADDR_W-1:0]          first_addr;
	logic [kmeans_ctrl_pkg::PT_ADDR_W-1:0]          last_addr;
	logic                                           converge_res_available;
	logic                                           has_converged;
	logic                                           irq;
	logic                                           go_signal;
	kmeans_ctrl_pkg::reg_id_e                       reg_num;
	logic                                           reg_write;
	kmeans_ctrl_pkg::ram_ctrl_t                     ram;
	kmeans_ctrl_pkg::classify_ctrl_t                classify;
	logic [N_CENT-1:0]                              centroid_en;
	logic [kmeans_ctrl_pkg::cent_cnt_w(N_CENT)-1:0] cent_cnt;
	kmeans_ctrl_pkg::converge_ctrl_t                converge;

	logic [31:0] lfsr_q;
	run_t        runs [N_RUNS];
	int          cur_k;      // convergence model target
	int          results;    // results handed out this run
	int          wd_cycles;
	int          n_checks;
	int          n_errors;
	int          exp_addr [$];  // expected values of the current run
	int          exp_load [$];
	int          exp_wb   [$];
	int          exp_walks;
	int          addr_idx;   // monitor state
	int          load_idx;
	int          wb_idx;
	int          walk_pos;
	int          walks;
	int          res_seen;
	logic        scan_seen;  // read window opened this run
	logic [N_CENT-1:0] en_q;
	logic        irq_q;
	logic        go_q;

	kmeans_ctrl_top #(.N_CENT(N_CENT)) dut (
		.clk                    (clk),
		.rst_n                  (rst_n),
		.go                     (go),
		.first_addr             (first_addr),
		.last_addr              (last_addr),
		.irq                    (irq),
		.go_signal              (go_signal),
		.reg_num                (reg_num),
		.reg_write              (reg_write),
		.ram                    (ram),
		.classify               (classify),
		.centroid_en            (centroid_en),
		.cent_cnt               (cent_cnt),
		.converge               (converge),
		.converge_res_available (converge_res_available),
		.has_converged          (has_converged)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;  // 100 ns period
	end

	// galois LFSR stepped once per bit taken
	function automatic int rand_bits(input int nbits);
		int val;
		int i;
		val = 0;
		for (i = 0; i < nbits; i++) begin
			lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h80200003) : (lfsr_q >> 1);
			val    = (val << 1) | lfsr_q[0];
		end
		return val;
	endfunction

	task automatic check_val(input string what, input logic [31:0] got, input logic [31:0] exp);
		n_checks++;
		if (got !== exp) begin
			n_errors++;
			$display("FAILED at %0t: %s, got %0h, expected %0h", $time, what, got, exp);
		end
	endtask

	// reference model fills the expected lists and returns the walk count
	function automatic int build_expected(input int first, input int last, input int k,
		input int n_cent);
		int it;
		int a;
		int c;
		exp_addr.delete();
		exp_load.delete();
		exp_wb.delete();
		for (it = 0; it < k; it++)
			for (a = first; a <= last; a++)
				exp_addr.push_back(a);  // one full scan per iteration
		for (c = 0; c < n_cent; c++) begin
			exp_load.push_back(int'(kmeans_ctrl_pkg::REG_CENT_1) + c);
			exp_wb.push_back(int'(kmeans_ctrl_pkg::REG_CENT_1) + c);
		end
		return k;  // one walk per convergence check
	endfunction

	initial begin : stimulus
		int r;
		int total;
		rst_n      = 1'b0;
		go         = 1'b0;
		first_addr = '0;
		last_addr  = '0;
		lfsr_q     = 32'h8fa0;
		n_checks   = 0;
		n_errors   = 0;
		results    = 0;
		cur_k      = 0;
		total      = 0;
		for (r = 0; r < N_RUNS; r++) begin
			runs[r].len   = rand_bits(5) % 20 + 1;
			runs[r].first = rand_bits(9) % (513 - runs[r].len);  // window ends by 511
			runs[r].k     = rand_bits(2) % 3 + 1;
			total += 4 * N_CENT + runs[r].k * (runs[r].len + N_CENT + 12) + 10;
		end
		wd_cycles = 2 * total;
		repeat (9) @(posedge clk);
		@(negedge clk);  // values held in reset
		check_val("reset cs_n", ram.cs_n, 1);
		check_val("reset oe_n", ram.oe_n, 1);
		check_val("reset we_n", ram.we_n, 1);
		check_val("reset reg_write", reg_write, 0);
		check_val("reset irq", irq, 0);
		check_val("reset go_signal", go_signal, 0);
		check_val("reset accum_en", classify.accum_en, 0);
		check_val("reset divider_en", converge.divider_en, 0);
		check_val("reset centroid_en", centroid_en, 0);
		check_val("reset first_iteration", classify.first_iteration, 1);
		check_val("reset conv_rst_n", converge.conv_rst_n, 0);
		check_val("reset pipe3_rst_n", classify.pipe3_rst_n, 0);
		@(posedge clk);
		rst_n <= 1'b1;
		repeat (3) @(posedge clk);
		check_val("idle irq", irq, 0);
		check_val("idle cs_n", ram.cs_n, 1);
		for (r = 0; r < N_RUNS; r++) begin
			exp_walks = build_expected(runs[r].first, runs[r].first + runs[r].len - 1,
				runs[r].k, N_CENT);
			cur_k   = runs[r].k;
			results = 0;
			@(posedge clk);
			first_addr <= kmeans_ctrl_pkg::PT_ADDR_W'(runs[r].first);
			last_addr  <= kmeans_ctrl_pkg::PT_ADDR_W'(runs[r].first + runs[r].len - 1);
			go         <= 1'b1;
			@(posedge clk);
			go <= 1'b0;
			@(posedge clk);  // old irq cleared by now
			while (!irq)
				@(posedge clk);
			repeat (2 + r) @(posedge clk);  // idle gap
			check_val("irq held until next go", irq, 1);
		end
		$display("checks: %0d, errors: %0d", n_checks, n_errors);
		if (n_errors == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

	// convergence block model with one result per conv_reg_en rise
	initial begin : conv_model
		int   delay;
		logic en_prev;
		converge_res_available = 1'b0;
		has_converged          = 1'b0;
		en_prev                = 1'b0;
		forever begin
			@(posedge clk);
			if (converge.conv_reg_en && !en_prev) begin
				delay = N_CENT + 1 + rand_bits(2);  // counted from the rise
				repeat (delay - 1) @(posedge clk);
				results = results + 1;
				converge_res_available <= 1'b1;
				has_converged          <= (results == cur_k);
				@(posedge clk);
				converge_res_available <= 1'b0;
				has_converged          <= 1'b0;
			end
			en_prev = converge.conv_reg_en;
		end
	end

	always @(posedge clk) begin : monitor
		if (!rst_n) begin
			en_q  = '0;
			irq_q = 1'b0;
			go_q  = 1'b0;
		end else begin
			if (go) begin  // DUT takes go on this edge
				addr_idx  = 0;
				load_idx  = 0;
				wb_idx    = 0;
				walk_pos  = 0;
				walks     = 0;
				res_seen  = 0;
				scan_seen = 1'b0;
			end
			if (!ram.cs_n && !ram.oe_n) begin
				if (!scan_seen)
					check_val("centroids loaded before first read", load_idx, N_CENT);
				scan_seen = 1'b1;
				check_val("we_n inside read window", ram.we_n, 1);
				check_val("in_reg_en inside read window", classify.in_reg_en, 1);
				check_val("point address", ram.addr,
					(addr_idx < exp_addr.size()) ? exp_addr[addr_idx] : -1);
				addr_idx++;
			end
			if (centroid_en != '0 && centroid_en != en_q) begin
				if (!scan_seen) begin  // load sequence
					check_val("load centroid_en", centroid_en, 1 << load_idx);
					check_val("load reg_num", reg_num,
						(load_idx < exp_load.size()) ? exp_load[load_idx] : -1);
					check_val("reg_write during load", reg_write, 0);
					check_val("load cent_cnt", cent_cnt, load_idx);
					check_val("go_signal during load", go_signal, 1);
					load_idx++;
				end else begin
					check_val("walk centroid_en", centroid_en, 1 << walk_pos);
					if (walk_pos == N_CENT - 1) begin
						walk_pos = 0;
						walks++;
					end else
						walk_pos++;
				end
			end
			if (converge_res_available) begin
				res_seen++;
				check_val("walks done at convergence result", walks, res_seen);
				check_val("walk finished before result", walk_pos, 0);
			end
			if (reg_write) begin
				check_val("writeback reg_num", reg_num,
					(wb_idx < exp_wb.size()) ? exp_wb[wb_idx] : -1);
				wb_idx++;
			end
			if (irq && !irq_q) begin  // end of run
				check_val("addresses in run", addr_idx, exp_addr.size());
				check_val("writebacks before irq", wb_idx, exp_wb.size());
				check_val("centroid walks in run", walks, exp_walks);
				check_val("go_signal dropped at irq", go_signal, 0);
			end
			if (!irq && irq_q)
				check_val("go before irq cleared", go_q, 1);
			en_q  = centroid_en;
			irq_q = irq;
			go_q  = go;
		end
	end

	initial begin : watchdog
		wait (wd_cycles > 0);
		repeat (wd_cycles) @(posedge clk);
		$display("watchdog expired, runs did not finish within %0d cycles", wd_cycles);
		$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

/* build.f */
hdl/kmeans_ctrl_pkg.sv
hdl/kmeans_phase_fsm.sv
hdl/point_addr_gen.sv
hdl/centroid_seq.sv
hdl/iteration_ctrl.sv
hdl/kmeans_ctrl_top.sv
verification/kmeans_ctrl_tb.sv

/* Bender.yml */
package:
  name: kmeans_ctrl

sources:
  - hdl/kmeans_ctrl_pkg.sv
  - hdl/kmeans_phase_fsm.sv
  - hdl/point_addr_gen.sv
  - hdl/centroid_seq.sv
  - hdl/iteration_ctrl.sv
  - hdl/kmeans_ctrl_top.sv
  - target: test
    files:
      - verification/kmeans_ctrl_tb.sv
